// File: common/tmu_pkg.sv
////////////////////
// Texture cache shared definitions.
// Address geometry, texel address decoding
// and the request and response words.
////////////////////

package tmu_pkg;

	// Geometry of the 8 KiB direct-mapped cache.
	localparam int TADR_W = 25;
	localparam int FML_W = 26;
	localparam int TAG_W = 13;
	localparam int INDEX_W = 8;
	localparam int BEAT_W = 2;
	localparam int LANE_W = 2;

	// Pass-through fields of a request.
	localparam int DADR_W = 24;
	localparam int FRAC_W = 6;

	// Texel address split into its cache fields.
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [INDEX_W-1:0] index;
		logic [BEAT_W-1:0] beat;
		logic [LANE_W-1:0] lane;
	} tex_fields_t;

	// One texel address, seen as a word address or as cache fields.
	typedef union packed {
		logic [TADR_W-1:0] raw;
		tex_fields_t f;
	} tex_adr_u;

	typedef struct packed {
		logic [DADR_W-1:0] dadr;
		tex_adr_u tadr_a;
		tex_adr_u tadr_b;
		tex_adr_u tadr_c;
		tex_adr_u tadr_d;
		logic [FRAC_W-1:0] x_frac;
		logic [FRAC_W-1:0] y_frac;
	} tmu_req_t;

	typedef struct packed {
		logic [DADR_W-1:0] dadr;
		logic [15:0] color_a;
		logic [15:0] color_b;
		logic [15:0] color_c;
		logic [15:0] color_d;
		logic [FRAC_W-1:0] x_frac;
		logic [FRAC_W-1:0] y_frac;
	} tmu_resp_t;

	typedef struct packed {
		logic valid;
		logic [TAG_W-1:0] tag;
	} tag_entry_t;

endpackage

// File: rtl/tmu_qpram.sv
////////////////////
// Quad read port RAM.
// Four registered read ports, one write port.
////////////////////

`timescale 1ns/1ps

module tmu_qpram #(
	parameter int adr_w = 8,
	parameter int data_w = 14
) (
	input  logic              sys_clk,

	input  logic [adr_w-1:0]  rd_adr_a_i,
	input  logic [adr_w-1:0]  rd_adr_b_i,
	input  logic [adr_w-1:0]  rd_adr_c_i,
	input  logic [adr_w-1:0]  rd_adr_d_i,
	output logic [data_w-1:0] rd_data_a_o,
	output logic [data_w-1:0] rd_data_b_o,
	output logic [data_w-1:0] rd_data_c_o,
	output logic [data_w-1:0] rd_data_d_o,

	input  logic              wr_en_i,
	input  logic [adr_w-1:0]  wr_adr_i,
	input  logic [data_w-1:0] wr_data_i
);

	logic [data_w-1:0] mem [0:(1<<adr_w)-1];

	// Reads return the old word when the same entry is written.
	always_ff @(posedge sys_clk) begin
		if (wr_en_i)
			mem[wr_adr_i] <= wr_data_i;
		rd_data_a_o <= mem[rd_adr_a_i];
		rd_data_b_o <= mem[rd_adr_b_i];
		rd_data_c_o <= mem[rd_adr_c_i];
		rd_data_d_o <= mem[rd_adr_d_i];
	end

endmodule

// File: texcache/tmu_tag_check.sv
////////////////////
// Texture cache lookup stage.
// Checks the four tags, picks the texels,
// holds the response and flags the first miss.
////////////////////

`timescale 1ns/1ps

module tmu_tag_check (
	input  logic                  sys_clk,
	input  logic                  sys_rst,

	input  tmu_pkg::tmu_req_t     req_i,
	input  logic                  in_valid_i,
	output logic                  in_ready_o,

	output tmu_pkg::tmu_resp_t    resp_o,
	output logic                  out_valid_o,
	input  logic                  out_ready_i,

	input  tmu_pkg::tag_entry_t   tag_a_i,
	input  tmu_pkg::tag_entry_t   tag_b_i,
	input  tmu_pkg::tag_entry_t   tag_c_i,
	input  tmu_pkg::tag_entry_t   tag_d_i,
	input  logic [63:0]           line_a_i,
	input  logic [63:0]           line_b_i,
	input  logic [63:0]           line_c_i,
	input  logic [63:0]           line_d_i,
	input  logic                  tag_wr_i,

	output logic                  miss_o,
	output tmu_pkg::tex_adr_u     miss_adr_o,
	output logic                  pending_o
);

	tmu_pkg::tmu_req_t req_r;
	logic pending;
	logic tag_wr_r;
	logic ignore_b, ignore_c, ignore_d;
	logic hit_a, hit_b, hit_c, hit_d;
	logic all_hit;
	logic complete;

	function automatic logic [15:0] sel_lane(input logic [63:0] line,
			input logic [tmu_pkg::LANE_W-1:0] lane);
		return line[{lane, 4'b0000} +: 16];
	endfunction

	// The request is registered alongside the RAM reads.
	always_ff @(posedge sys_clk) begin
		if (in_valid_i && in_ready_o)
			req_r <= req_i;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pending <= 1'b0;
			tag_wr_r <= 1'b0;
		end else begin
			pending <= (in_valid_i && in_ready_o) || (pending && !complete);
			tag_wr_r <= tag_wr_i;
		end
	end

	// Texels on an integer coordinate are unused.
	assign ignore_b = (req_r.x_frac == '0);
	assign ignore_c = (req_r.y_frac == '0);
	assign ignore_d = ignore_b || ignore_c;

	// Data read just after a tag write is stale.
	assign hit_a = !tag_wr_r && tag_a_i.valid && (tag_a_i.tag == req_r.tadr_a.f.tag);
	assign hit_b = ignore_b ||
		(!tag_wr_r && tag_b_i.valid && (tag_b_i.tag == req_r.tadr_b.f.tag));
	assign hit_c = ignore_c ||
		(!tag_wr_r && tag_c_i.valid && (tag_c_i.tag == req_r.tadr_c.f.tag));
	assign hit_d = ignore_d ||
		(!tag_wr_r && tag_d_i.valid && (tag_d_i.tag == req_r.tadr_d.f.tag));
	assign all_hit = hit_a && hit_b && hit_c && hit_d;

	assign complete = pending && all_hit && (!out_valid_o || out_ready_i);
	assign in_ready_o = !pending || complete;
	assign pending_o = pending;

	// Response register.
	always_ff @(posedge sys_clk) begin
		if (complete) begin
			resp_o.dadr <= req_r.dadr;
			resp_o.color_a <= sel_lane(line_a_i, req_r.tadr_a.f.lane);
			resp_o.color_b <= sel_lane(line_b_i, req_r.tadr_b.f.lane);
			resp_o.color_c <= sel_lane(line_c_i, req_r.tadr_c.f.lane);
			resp_o.color_d <= sel_lane(line_d_i, req_r.tadr_d.f.lane);
			resp_o.x_frac <= req_r.x_frac;
			resp_o.y_frac <= req_r.y_frac;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			out_valid_o <= 1'b0;
		else
			out_valid_o <= complete || (out_valid_o && !out_ready_i);
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			miss_o <= 1'b0;
		else
			miss_o <= pending && !all_hit;
	end

	// First missing texel, in A, B, C, D order.
	always_ff @(posedge sys_clk) begin
		if (pending) begin
			if (!hit_a)
				miss_adr_o <= req_r.tadr_a;
			else if (!hit_b)
				miss_adr_o <= req_r.tadr_b;
			else if (!hit_c)
				miss_adr_o <= req_r.tadr_c;
			else if (!hit_d)
				miss_adr_o <= req_r.tadr_d;
		end
	end

endmodule

// File: texcache/tmu_line_fetch.sv
////////////////////
// Texture cache line fetch.
// Bursts a missing line from memory,
// refills data and tags, and runs the flush.
////////////////////

`timescale 1ns/1ps

module tmu_line_fetch (
	input  logic                                         sys_clk,
	input  logic                                         sys_rst,

	input  logic                                         miss_i,
	input  tmu_pkg::tex_adr_u                            miss_adr_i,
	input  logic                                         pending_i,
	input  logic                                         flush_i,

	output logic                                         fml_stb_o,
	output logic [tmu_pkg::FML_W-1:0]                    fml_adr_o,
	input  logic                                         fml_ack_i,
	input  logic [63:0]                                  fml_di_i,

	output logic                                         tag_wr_o,
	output logic [tmu_pkg::INDEX_W-1:0]                  tag_wr_adr_o,
	output tmu_pkg::tag_entry_t                          tag_wr_data_o,
	output logic                                         data_wr_en_o,
	output logic [tmu_pkg::INDEX_W+tmu_pkg::BEAT_W-1:0]  data_wr_adr_o,
	output logic [63:0]                                  data_wr_data_o,
	output logic                                         busy_o
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_BEAT0,
		S_BEAT1,
		S_BEAT2,
		S_BEAT3,
		S_WAIT1,
		S_WAIT2,
		S_FLUSH
	} state_t;

	state_t state, state_next;
	tmu_pkg::tex_adr_u fetch_adr;
	tmu_pkg::tex_adr_u cur_adr;
	logic [tmu_pkg::BEAT_W-1:0] beat_cnt;
	logic [tmu_pkg::INDEX_W-1:0] flush_cnt;
	logic flush_mode;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			state <= S_IDLE;
		else
			state <= state_next;
	end

	// Miss address is captured while idle and held for the burst.
	always_ff @(posedge sys_clk) begin
		if (state == S_IDLE)
			fetch_adr <= miss_adr_i;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			beat_cnt <= '0;
		else if (data_wr_en_o)
			beat_cnt <= beat_cnt + 1'b1;
		else if (state == S_IDLE)
			beat_cnt <= '0;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst || state != S_FLUSH)
			flush_cnt <= '0;
		else
			flush_cnt <= flush_cnt + 1'b1;
	end

	always_comb begin
		state_next = state;
		fml_stb_o = 1'b0;
		data_wr_en_o = 1'b0;
		tag_wr_o = 1'b0;
		flush_mode = 1'b0;
		case (state)
			S_IDLE: begin
				if (flush_i) begin
					state_next = S_FLUSH;
				end else if (miss_i) begin
					fml_stb_o = 1'b1;
					data_wr_en_o = fml_ack_i;
					state_next = fml_ack_i ? S_BEAT1 : S_BEAT0;
				end
			end
			S_BEAT0: begin
				fml_stb_o = 1'b1;
				if (fml_ack_i) begin
					data_wr_en_o = 1'b1;
					state_next = S_BEAT1;
				end
			end
			S_BEAT1: begin
				data_wr_en_o = 1'b1;
				state_next = S_BEAT2;
			end
			S_BEAT2: begin
				data_wr_en_o = 1'b1;
				state_next = S_BEAT3;
			end
			S_BEAT3: begin
				// Tag goes in last, since it lets the lookup hit.
				data_wr_en_o = 1'b1;
				tag_wr_o = 1'b1;
				state_next = S_WAIT1;
			end
			S_WAIT1: state_next = S_WAIT2;
			S_WAIT2: state_next = S_IDLE;
			S_FLUSH: begin
				tag_wr_o = 1'b1;
				flush_mode = 1'b1;
				if (&flush_cnt)
					state_next = S_IDLE;
			end
			default: state_next = S_IDLE;
		endcase
	end

	assign cur_adr = (state == S_IDLE) ? miss_adr_i : fetch_adr;

	assign fml_adr_o = {cur_adr.f.tag, cur_adr.f.index,
		{(tmu_pkg::FML_W-tmu_pkg::TAG_W-tmu_pkg::INDEX_W){1'b0}}};

	assign data_wr_adr_o = {cur_adr.f.index, beat_cnt};
	assign data_wr_data_o = fml_di_i;

	assign tag_wr_adr_o = flush_mode ? flush_cnt : fetch_adr.f.index;
	assign tag_wr_data_o = '{valid: !flush_mode, tag: fetch_adr.f.tag};

	assign busy_o = (state != S_IDLE) || pending_i;

endmodule

// File: texcache/tmu_texcache.sv
////////////////////
// Texture cache top level.
// Tag and data RAMs, lookup and line fetch.
////////////////////

`timescale 1ns/1ps

module tmu_texcache (
	input  logic                      sys_clk,
	input  logic                      sys_rst,

	input  tmu_pkg::tmu_req_t         req_i,
	input  logic                      in_valid_i,
	output logic                      in_ready_o,

	output tmu_pkg::tmu_resp_t        resp_o,
	output logic                      out_valid_o,
	input  logic                      out_ready_i,

	input  logic                      flush_i,
	output logic                      busy_o,

	output logic                      fml_stb_o,
	output logic [tmu_pkg::FML_W-1:0] fml_adr_o,
	input  logic                      fml_ack_i,
	input  logic [63:0]               fml_di_i
);

	tmu_pkg::tag_entry_t tag_a, tag_b, tag_c, tag_d;
	logic [63:0] line_a, line_b, line_c, line_d;
	logic tag_wr;
	logic [tmu_pkg::INDEX_W-1:0] tag_wr_adr;
	tmu_pkg::tag_entry_t tag_wr_data;
	logic data_wr_en;
	logic [tmu_pkg::INDEX_W+tmu_pkg::BEAT_W-1:0] data_wr_adr;
	logic [63:0] data_wr_data;
	logic miss;
	tmu_pkg::tex_adr_u miss_adr;
	logic pending;

	tmu_qpram #(
		.adr_w(tmu_pkg::INDEX_W),
		.data_w($bits(tmu_pkg::tag_entry_t))
	) tag_ram (
		.sys_clk(sys_clk),
		.rd_adr_a_i(req_i.tadr_a.f.index),
		.rd_adr_b_i(req_i.tadr_b.f.index),
		.rd_adr_c_i(req_i.tadr_c.f.index),
		.rd_adr_d_i(req_i.tadr_d.f.index),
		.rd_data_a_o(tag_a),
		.rd_data_b_o(tag_b),
		.rd_data_c_o(tag_c),
		.rd_data_d_o(tag_d),
		.wr_en_i(tag_wr),
		.wr_adr_i(tag_wr_adr),
		.wr_data_i(tag_wr_data)
	);

	// Data words are addressed by line index and beat.
	tmu_qpram #(
		.adr_w(tmu_pkg::INDEX_W + tmu_pkg::BEAT_W),
		.data_w(64)
	) data_ram (
		.sys_clk(sys_clk),
		.rd_adr_a_i({req_i.tadr_a.f.index, req_i.tadr_a.f.beat}),
		.rd_adr_b_i({req_i.tadr_b.f.index, req_i.tadr_b.f.beat}),
		.rd_adr_c_i({req_i.tadr_c.f.index, req_i.tadr_c.f.beat}),
		.rd_adr_d_i({req_i.tadr_d.f.index, req_i.tadr_d.f.beat}),
		.rd_data_a_o(line_a),
		.rd_data_b_o(line_b),
		.rd_data_c_o(line_c),
		.rd_data_d_o(line_d),
		.wr_en_i(data_wr_en),
		.wr_adr_i(data_wr_adr),
		.wr_data_i(data_wr_data)
	);

	tmu_tag_check tag_check (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.req_i(req_i),
		.in_valid_i(in_valid_i),
		.in_ready_o(in_ready_o),
		.resp_o(resp_o),
		.out_valid_o(out_valid_o),
		.out_ready_i(out_ready_i),
		.tag_a_i(tag_a),
		.tag_b_i(tag_b),
		.tag_c_i(tag_c),
		.tag_d_i(tag_d),
		.line_a_i(line_a),
		.line_b_i(line_b),
		.line_c_i(line_c),
		.line_d_i(line_d),
		.tag_wr_i(tag_wr),
		.miss_o(miss),
		.miss_adr_o(miss_adr),
		.pending_o(pending)
	);

	tmu_line_fetch line_fetch (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.miss_i(miss),
		.miss_adr_i(miss_adr),
		.pending_i(pending),
		.flush_i(flush_i),
		.fml_stb_o(fml_stb_o),
		.fml_adr_o(fml_adr_o),
		.fml_ack_i(fml_ack_i),
		.fml_di_i(fml_di_i),
		.tag_wr_o(tag_wr),
		.tag_wr_adr_o(tag_wr_adr),
		.tag_wr_data_o(tag_wr_data),
		.data_wr_en_o(data_wr_en),
		.data_wr_adr_o(data_wr_adr),
		.data_wr_data_o(data_wr_data),
		.busy_o(busy_o)
	);

endmodule

// File: test/tmu_texcache_properties.sv
////////////////////
// Texture cache handshake properties.
// Bound to the top level.
////////////////////

`timescale 1ns/1ps

module tmu_texcache_properties (
	input  logic               sys_clk,
	input  logic               sys_rst,
	input  logic               fml_stb_o,
	input  logic               fml_ack_i,
	input  logic               out_valid_o,
	input  logic               out_ready_i,
	input  logic               in_ready_o,
	input  tmu_pkg::tmu_resp_t resp_o
);

	// The strobe stays up until memory acknowledges.
	stb_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fml_stb_o && !fml_ack_i |=> fml_stb_o)
		else $error("fml_stb_o dropped before the acknowledge");

	// A stalled response keeps its valid and its value.
	resp_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(resp_o))
		else $error("resp_o changed under back-pressure");

	ready_after_reset: assert property (@(posedge sys_clk)
		$fell(sys_rst) |-> in_ready_o)
		else $error("in_ready_o low one cycle after reset");

endmodule

bind tmu_texcache tmu_texcache_properties props_i (
	.sys_clk(sys_clk),
	.sys_rst(sys_rst),
	.fml_stb_o(fml_stb_o),
	.fml_ack_i(fml_ack_i),
	.out_valid_o(out_valid_o),
	.out_ready_i(out_ready_i),
	.in_ready_o(in_ready_o),
	.resp_o(resp_o)
);

// File: test/tmu_texcache_checker.sv
////////////////////
// Texture cache response checker.
// Compares accepted responses in order
// and counts memory fetches.
////////////////////

`timescale 1ns/1ps

module tmu_texcache_checker (
	input  logic               sys_clk,
	input  logic               sys_rst,
	input  tmu_pkg::tmu_resp_t resp_i,
	input  logic               out_valid_i,
	input  logic               out_ready_i,
	input  logic               fml_stb_i,
	input  logic               fml_ack_i
);

	tmu_pkg::tmu_resp_t exp_q[$];
	logic [2:0] ign_q[$];
	string name_q[$];
	int resp_count = 0;
	int fetch_count = 0;
	int errors = 0;

	// Ignore bits are ordered B, C, D.
	task automatic push_expect(input tmu_pkg::tmu_resp_t e, input logic [2:0] ign,
			input string name);
		exp_q.push_back(e);
		ign_q.push_back(ign);
		name_q.push_back(name);
	endtask

	function automatic int outstanding();
		return exp_q.size();
	endfunction

	task automatic compare_field(input string name, input string field,
			input logic [23:0] exp_v, input logic [23:0] act_v);
		if (exp_v !== act_v) begin
			errors++;
			$display("Mismatch %s %s: expected %h, actual %h", name, field, exp_v, act_v);
		end
	endtask

	always @(posedge sys_clk) begin
		tmu_pkg::tmu_resp_t e;
		logic [2:0] ign;
		string name;
		if (!sys_rst) begin
			if (fml_stb_i && fml_ack_i)
				fetch_count++;
			if (out_valid_i && out_ready_i) begin
				resp_count++;
				if (exp_q.size() == 0) begin
					errors++;
					$display("Response accepted with no request outstanding");
				end else begin
					e = exp_q.pop_front();
					ign = ign_q.pop_front();
					name = name_q.pop_front();
					compare_field(name, "dadr", e.dadr, resp_i.dadr);
					compare_field(name, "color_a", 24'(e.color_a), 24'(resp_i.color_a));
					if (!ign[2])
						compare_field(name, "color_b", 24'(e.color_b), 24'(resp_i.color_b));
					if (!ign[1])
						compare_field(name, "color_c", 24'(e.color_c), 24'(resp_i.color_c));
					if (!ign[0])
						compare_field(name, "color_d", 24'(e.color_d), 24'(resp_i.color_d));
					compare_field(name, "x_frac", 24'(e.x_frac), 24'(resp_i.x_frac));
					compare_field(name, "y_frac", 24'(e.y_frac), 24'(resp_i.y_frac));
				end
			end
		end
	end

endmodule

// File: test/tb_tmu_texcache.sv
////////////////////
// Texture cache testbench.
// Clock, reset, memory model, request table
// and the closing report.
////////////////////

`timescale 1ns/1ps

module tb_tmu_texcache;

	localparam int CLK_PERIOD = 100;
	localparam int TIMEOUT = 2000;
	localparam int N_ROWS = 11;

	logic sys_clk = 1'b0;
	logic sys_rst = 1'b1;
	tmu_pkg::tmu_req_t req_i;
	logic in_valid_i, in_ready_o;
	tmu_pkg::tmu_resp_t resp_o;
	logic out_valid_o, out_ready_i;
	logic flush_i, busy_o;
	logic fml_stb_o, fml_ack_i;
	logic [tmu_pkg::FML_W-1:0] fml_adr_o;
	logic [63:0] fml_di_i;

	integer seed;
	int cyc = 0;
	int tb_errors = 0;
	int tests = 0;
	int failed = 0;
	int expected_total = 0;
	bit aborted = 0;
	bit bp_on = 0;
	string cur_name = "";

	// Memory model state.
	int wait_cnt;
	int beats_left = 0;
	logic [tmu_pkg::FML_W-1:0] burst_adr;

	// Request table.
	string names[N_ROWS];
	tmu_pkg::tmu_req_t reqs[N_ROWS];
	int fetches[N_ROWS];
	bit bp[N_ROWS];
	bit fl[N_ROWS];
	int n_rows = 0;

	tmu_texcache tmu_texcache_i (.*);

	tmu_texcache_checker checker_i (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.resp_i(resp_o),
		.out_valid_i(out_valid_o),
		.out_ready_i(out_ready_i),
		.fml_stb_i(fml_stb_o),
		.fml_ack_i(fml_ack_i)
	);

	always #(CLK_PERIOD/2) sys_clk = ~sys_clk;

	always @(posedge sys_clk)
		cyc <= cyc + 1;

	function automatic logic [15:0] texel_value(input logic [24:0] w);
		return w[15:0] ^ 16'hA5C3;
	endfunction

	function automatic logic [63:0] beat_word(input logic [25:0] badr, input int beat);
		logic [24:0] w;
		logic [63:0] d;
		for (int lane = 0; lane < 4; lane++) begin
			w = badr[25:1] + 25'(4 * beat + lane);
			d[16*lane +: 16] = texel_value(w);
		end
		return d;
	endfunction

	// A line may be fetched only for a texel that the filter uses.
	function automatic bit line_used(input logic [25:0] adr, input tmu_pkg::tmu_req_t r);
		bit used;
		used = (adr == {r.tadr_a.raw[24:4], 5'b00000});
		if (r.x_frac != 6'd0)
			used = used || (adr == {r.tadr_b.raw[24:4], 5'b00000});
		if (r.y_frac != 6'd0)
			used = used || (adr == {r.tadr_c.raw[24:4], 5'b00000});
		if (r.x_frac != 6'd0 && r.y_frac != 6'd0)
			used = used || (adr == {r.tadr_d.raw[24:4], 5'b00000});
		return used;
	endfunction

	// Memory answers the strobe after 0 to 3 cycles, then streams three more beats.
	always @(negedge sys_clk) begin
		if (sys_rst) begin
			fml_ack_i = 1'b0;
			beats_left = 0;
		end else if (beats_left > 0) begin
			fml_ack_i = 1'b0;
			fml_di_i = beat_word(burst_adr, 4 - beats_left);
			beats_left--;
		end else if (fml_stb_o && !fml_ack_i) begin
			if (wait_cnt == 0) begin
				burst_adr = fml_adr_o;
				if (!line_used(fml_adr_o, req_i)) begin
					$display("Mismatch %s fetch address: expected a line of the request, actual %h",
						cur_name, fml_adr_o);
					tb_errors++;
				end
				fml_ack_i = 1'b1;
				fml_di_i = beat_word(burst_adr, 0);
				beats_left = 3;
				wait_cnt = {$random(seed)} % 4;
			end else begin
				wait_cnt--;
			end
		end else begin
			fml_ack_i = 1'b0;
		end
	end

	always @(negedge sys_clk) begin
		int r;
		r = $random(seed);
		out_ready_i = bp_on ? r[0] : 1'b1;
	end

	task automatic add_row(input string name, input logic [23:0] dadr,
			input logic [24:0] a, input logic [24:0] b, input logic [24:0] c,
			input logic [24:0] d, input logic [5:0] xf, input logic [5:0] yf,
			input int nf, input bit bpf, input bit flf);
		names[n_rows] = name;
		reqs[n_rows].dadr = dadr;
		reqs[n_rows].tadr_a.raw = a;
		reqs[n_rows].tadr_b.raw = b;
		reqs[n_rows].tadr_c.raw = c;
		reqs[n_rows].tadr_d.raw = d;
		reqs[n_rows].x_frac = xf;
		reqs[n_rows].y_frac = yf;
		fetches[n_rows] = nf;
		bp[n_rows] = bpf;
		fl[n_rows] = flf;
		n_rows++;
	endtask

	task automatic expect_row(input int i);
		tmu_pkg::tmu_resp_t e;
		logic [2:0] ign;
		e.dadr = reqs[i].dadr;
		e.color_a = texel_value(reqs[i].tadr_a.raw);
		e.color_b = texel_value(reqs[i].tadr_b.raw);
		e.color_c = texel_value(reqs[i].tadr_c.raw);
		e.color_d = texel_value(reqs[i].tadr_d.raw);
		e.x_frac = reqs[i].x_frac;
		e.y_frac = reqs[i].y_frac;
		ign[2] = (reqs[i].x_frac == 6'd0);
		ign[1] = (reqs[i].y_frac == 6'd0);
		ign[0] = ign[2] || ign[1];
		checker_i.push_expect(e, ign, names[i]);
		expected_total++;
	endtask

	// Holds the request on the input until the cache accepts it.
	task automatic send_req(input int i);
		int n;
		bit acc;
		n = 0;
		acc = 0;
		@(negedge sys_clk);
		req_i = reqs[i];
		in_valid_i = 1'b1;
		while (!acc && n < TIMEOUT && !aborted) begin
			@(posedge sys_clk);
			acc = in_ready_o;
			n++;
		end
		if (!acc && !aborted) begin
			$display("Timeout: request of test %s was never accepted", names[i]);
			aborted = 1;
		end
	endtask

	task automatic wait_responses();
		int n;
		n = 0;
		while (checker_i.resp_count < expected_total && n < TIMEOUT && !aborted) begin
			@(negedge sys_clk);
			n++;
		end
		if (checker_i.resp_count < expected_total && !aborted) begin
			$display("Timeout: %0d responses arrived, %0d expected",
				checker_i.resp_count, expected_total);
			aborted = 1;
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy_o && n < TIMEOUT && !aborted) begin
			@(negedge sys_clk);
			n++;
		end
		if (busy_o && !aborted) begin
			$display("Timeout: busy_o never dropped");
			aborted = 1;
		end
	endtask

	task automatic do_flush(input string name);
		int n;
		n = 0;
		@(negedge sys_clk);
		flush_i = 1'b1;
		@(negedge sys_clk);
		flush_i = 1'b0;
		while (busy_o && n < TIMEOUT) begin
			@(negedge sys_clk);
			n++;
		end
		if (busy_o) begin
			$display("Timeout: flush never finished");
			aborted = 1;
		end else if (n != 256) begin
			$display("Mismatch %s flush cycles: expected 256, actual %0d", name, n);
			tb_errors++;
		end
	endtask

	task automatic report(input string name, input int err0);
		tests++;
		if (tb_errors + checker_i.errors != err0 || aborted) begin
			failed++;
			$display("test %s failed", name);
		end else begin
			$display("test %s ok", name);
		end
	endtask

	initial begin
		int f0;
		int err0;
		int t0;
		int stream_rows[4];
		seed = 32'ha16e0526;
		wait_cnt = 0;
		req_i = '0;
		in_valid_i = 1'b0;
		out_ready_i = 1'b1;
		flush_i = 1'b0;
		fml_ack_i = 1'b0;
		fml_di_i = '0;
		stream_rows = '{1, 3, 4, 10};

		add_row("cold_quad", 24'h000101, 25'h000010, 25'h000011, 25'h000050,
			25'h000051, 6'd8, 6'd8, 2, 0, 0);
		add_row("hit_quad", 24'h000102, 25'h000012, 25'h000013, 25'h00005E,
			25'h00005F, 6'd8, 6'd8, 0, 0, 0);
		add_row("cold_four", 24'h000103, 25'h012340, 25'h012351, 25'h012362,
			25'h012373, 6'd1, 6'd63, 4, 0, 0);
		add_row("ignore_x", 24'h000104, 25'h000012, 25'h1F0000, 25'h000052,
			25'h1F0010, 6'd0, 6'd5, 0, 0, 0);
		add_row("ignore_y", 24'h000105, 25'h000013, 25'h000014, 25'h1E0000,
			25'h1E0020, 6'd7, 6'd0, 0, 0, 0);
		add_row("ignore_both", 24'h000106, 25'h0A0000, 25'h1D0000, 25'h1D0100,
			25'h1D0200, 6'd0, 6'd0, 1, 0, 0);
		add_row("conflict", 24'h000107, 25'h100010, 25'h100011, 25'h10001C,
			25'h10001D, 6'd3, 6'd3, 1, 0, 0);
		add_row("evicted", 24'h000108, 25'h000010, 25'h000011, 25'h000050,
			25'h000051, 6'd8, 6'd8, 1, 0, 0);
		add_row("bp_miss", 24'h000109, 25'h0B0000, 25'h0B0001, 25'h0B0004,
			25'h0B000F, 6'd9, 6'd2, 1, 1, 0);
		add_row("bp_hit", 24'h00010A, 25'h0B0002, 25'h0B0003, 25'h0B0008,
			25'h0B000C, 6'd9, 6'd2, 0, 1, 0);
		add_row("flush_repeat", 24'h00010B, 25'h000010, 25'h000011, 25'h000050,
			25'h000051, 6'd8, 6'd8, 2, 0, 1);

		repeat (16) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;
		@(negedge sys_clk);
		err0 = tb_errors;
		if (out_valid_o || fml_stb_o || busy_o || !in_ready_o) begin
			$display("Mismatch after_reset valid/stb/busy/ready: expected 0001, actual %b%b%b%b",
				out_valid_o, fml_stb_o, busy_o, in_ready_o);
			tb_errors++;
		end
		report("after_reset", err0);

		for (int i = 0; i < n_rows && !aborted; i++) begin
			err0 = tb_errors + checker_i.errors;
			cur_name = names[i];
			if (fl[i]) begin
				wait_idle();
				do_flush(names[i]);
			end
			bp_on = bp[i];
			f0 = checker_i.fetch_count;
			expect_row(i);
			send_req(i);
			@(negedge sys_clk);
			in_valid_i = 1'b0;
			wait_responses();
			wait_idle();
			bp_on = 0;
			if (checker_i.fetch_count - f0 != fetches[i]) begin
				$display("Mismatch %s fetches: expected %0d, actual %0d", names[i],
					fetches[i], checker_i.fetch_count - f0);
				tb_errors++;
			end
			report(names[i], err0);
		end

		// Resident requests back to back should stream one per cycle.
		if (!aborted) begin
			err0 = tb_errors + checker_i.errors;
			cur_name = "hit_stream";
			f0 = checker_i.fetch_count;
			foreach (stream_rows[k])
				expect_row(stream_rows[k]);
			t0 = cyc;
			foreach (stream_rows[k])
				send_req(stream_rows[k]);
			@(negedge sys_clk);
			in_valid_i = 1'b0;
			wait_responses();
			if (cyc - t0 > 7) begin
				$display("Mismatch hit_stream cycles: expected at most 7, actual %0d",
					cyc - t0);
				tb_errors++;
			end
			if (checker_i.fetch_count != f0) begin
				$display("Mismatch hit_stream fetches: expected 0, actual %0d",
					checker_i.fetch_count - f0);
				tb_errors++;
			end
			report("hit_stream", err0);
		end

		repeat (4) @(negedge sys_clk);
		if (checker_i.outstanding() != 0) begin
			$display("%0d expected responses never arrived", checker_i.outstanding());
			tb_errors++;
		end
		$display("tests %0d, failed %0d, errors %0d, responses %0d, fetches %0d",
			tests, failed, tb_errors + checker_i.errors, checker_i.resp_count,
			checker_i.fetch_count);
		if (failed == 0 && !aborted && tb_errors + checker_i.errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: flist.f
common/tmu_pkg.sv
rtl/tmu_qpram.sv
texcache/tmu_tag_check.sv
texcache/tmu_line_fetch.sv
texcache/tmu_texcache.sv
test/tmu_texcache_properties.sv
test/tmu_texcache_checker.sv
test/tb_tmu_texcache.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_tmu_texcache
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
